// ==== constellation_renderer.sv ====
// Constellation renderer top level
// Draws buffered 16-QAM symbols as coloured dots over a 640x480 video raster
`timescale 1ns/1ns

module constellation_renderer (
    input  logic                                clk_pixel,
    input  logic                                rst_n,
    input  logic signed [gdsp_pkg::SAMPLE_W-1:0] sym_i,
    input  logic signed [gdsp_pkg::SAMPLE_W-1:0] sym_q,
    input  logic                                sym_valid,
    output logic        [23:0]                  rgb_pixel,
    output logic                                hsync,
    output logic                                vsync,
    output logic                                de
);

    // Scan position and frame control
    logic [gdsp_pkg::H_CNT_W-1:0] h_cnt;
    logic [gdsp_pkg::V_CNT_W-1:0] v_cnt;
    logic                         video_active;
    logic                         frame_clear;

    // Mapper to buffer
    logic [gdsp_pkg::H_CNT_W-1:0] dot_x;
    logic [gdsp_pkg::V_CNT_W-1:0] dot_y;
    logic                         dot_write;

    // Buffer to colouriser
    logic                         pixel_hit;
    logic [1:0]                   hit_quadrant;

    video_timing_gen i_timing (
        .clk_pixel    (clk_pixel),
        .rst_n        (rst_n),
        .h_cnt        (h_cnt),
        .v_cnt        (v_cnt),
        .video_active (video_active),
        .hsync        (hsync),
        .vsync        (vsync),
        .de           (de),
        .frame_clear  (frame_clear)
    );

    symbol_mapper i_mapper (
        .clk_pixel (clk_pixel),
        .rst_n     (rst_n),
        .sym_i     (sym_i),
        .sym_q     (sym_q),
        .sym_valid (sym_valid),
        .dot_x     (dot_x),
        .dot_y     (dot_y),
        .dot_write (dot_write)
    );

    dot_store i_store (
        .clk_pixel    (clk_pixel),
        .rst_n        (rst_n),
        .frame_clear  (frame_clear),
        .dot_write    (dot_write),
        .dot_x        (dot_x),
        .dot_y        (dot_y),
        .h_cnt        (h_cnt),
        .v_cnt        (v_cnt),
        .pixel_hit    (pixel_hit),
        .hit_quadrant (hit_quadrant)
    );

    pixel_colorizer i_colorizer (
        .clk_pixel    (clk_pixel),
        .rst_n        (rst_n),
        .h_cnt        (h_cnt),
        .v_cnt        (v_cnt),
        .video_active (video_active),
        .pixel_hit    (pixel_hit),
        .hit_quadrant (hit_quadrant),
        .rgb_pixel    (rgb_pixel)
    );

endmodule : constellation_renderer

// ==== dot_store.sv ====
// Dot buffer
// Keeps up to MAX_DOTS screen positions for the current frame and reports
// whether the scan position falls inside one of them, with its quadrant
`timescale 1ns/1ns

module dot_store (
    input  logic                         clk_pixel,
    input  logic                         rst_n,
    input  logic                         frame_clear,
    input  logic                         dot_write,
    input  logic [gdsp_pkg::H_CNT_W-1:0] dot_x,
    input  logic [gdsp_pkg::V_CNT_W-1:0] dot_y,
    input  logic [gdsp_pkg::H_CNT_W-1:0] h_cnt,
    input  logic [gdsp_pkg::V_CNT_W-1:0] v_cnt,
    output logic                         pixel_hit,
    output logic [1:0]                   hit_quadrant
);

    // Stored positions
    logic [gdsp_pkg::H_CNT_W-1:0] pos_x [gdsp_pkg::MAX_DOTS];
    logic [gdsp_pkg::V_CNT_W-1:0] pos_y [gdsp_pkg::MAX_DOTS];

    // One flag per entry and the next slot to fill
    logic [gdsp_pkg::MAX_DOTS-1:0]  dot_valid;
    logic [gdsp_pkg::DOT_PTR_W-1:0] wr_ptr;

    // ====================
    // Write side
    // ====================
    // Position payload written into the pointer slot
    always_ff @(posedge clk_pixel) begin
        if (dot_write && !frame_clear) begin
            pos_x[wr_ptr] <= dot_x;
            pos_y[wr_ptr] <= dot_y;
        end
    end

    // Frame clear beats a write in the same cycle
    always_ff @(posedge clk_pixel or negedge rst_n) begin
        if (!rst_n) begin
            dot_valid <= '0;
            wr_ptr    <= '0;
        end else if (frame_clear) begin
            dot_valid <= '0;
            wr_ptr    <= '0;
        end else if (dot_write) begin
            dot_valid[wr_ptr] <= 1'b1;
            // Wraps past the last slot and overwrites the oldest dot
            wr_ptr            <= wr_ptr + 1'b1;
        end
    end

    // ====================
    // Hit test
    // ====================
    // Dot covers DOT_SIZE pixels right of and below its stored corner
    always_comb begin
        pixel_hit    = 1'b0;
        hit_quadrant = 2'b00;
        // Ascending scan lets the highest hitting index win
        for (int k = 0; k < gdsp_pkg::MAX_DOTS; k++) begin
            if (dot_valid[k] &&
                (h_cnt >= pos_x[k]) &&
                (h_cnt <  pos_x[k] + gdsp_pkg::H_CNT_W'(gdsp_pkg::DOT_SIZE)) &&
                (v_cnt >= pos_y[k]) &&
                (v_cnt <  pos_y[k] + gdsp_pkg::V_CNT_W'(gdsp_pkg::DOT_SIZE))) begin
                pixel_hit    = 1'b1;
                // Bit 1 for above centre and bit 0 for at or right of centre
                hit_quadrant = {(pos_y[k] < gdsp_pkg::V_CNT_W'(gdsp_pkg::CENTER_Y)),
                                (pos_x[k] >= gdsp_pkg::H_CNT_W'(gdsp_pkg::CENTER_X))};
            end
        end
    end

endmodule : dot_store

// ==== gdsp_pkg.sv ====
// Shared constants for the constellation renderer
// Video timing, IQ mapping, dot buffer sizing and display colours
package gdsp_pkg;

    // ====================
    // Sample format
    // ====================
    // I and Q arrive as Q1.11 signed words
    localparam int SAMPLE_W = 12;

    // ====================
    // 640x480 at 60 Hz timing
    // ====================
    // Horizontal, in pixel clocks
    localparam int H_ACTIVE = 640;
    localparam int H_FP     = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BP     = 48;
    localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;

    // Vertical, in lines
    localparam int V_ACTIVE = 480;
    localparam int V_FP     = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BP     = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;

    // Counter widths, 0..799 and 0..524
    localparam int H_CNT_W = 12;
    localparam int V_CNT_W = 11;

    // ====================
    // Plot mapping
    // ====================
    // Constellation origin on screen
    localparam int CENTER_X = 320;
    localparam int CENTER_Y = 240;
    // Divide by 8 before placing on screen
    localparam int SAMPLE_SHIFT = 3;
    // Edge of the square dot
    localparam int DOT_SIZE = 2;

    // Dot buffer depth and its pointer width
    localparam int MAX_DOTS  = 16;
    localparam int DOT_PTR_W = 4;

    // ====================
    // Colours, R in the high byte
    // ====================
    localparam logic [23:0] COLOR_Q1     = 24'h00FFFF;
    localparam logic [23:0] COLOR_Q2     = 24'h00FF00;
    localparam logic [23:0] COLOR_Q3     = 24'hFFFF00;
    localparam logic [23:0] COLOR_Q4     = 24'hFF00FF;
    localparam logic [23:0] COLOR_AXIS   = 24'hA0A0A0;
    localparam logic [23:0] COLOR_BORDER = 24'h505050;
    localparam logic [23:0] COLOR_BLACK  = 24'h000000;

endpackage : gdsp_pkg

// ==== pixel_colorizer.sv ====
// Pixel colouriser
// Picks the output colour for the scan position from dot hits,
// centre axes and the screen border, black during blanking
`timescale 1ns/1ns

module pixel_colorizer (
    input  logic                         clk_pixel,
    input  logic                         rst_n,
    input  logic [gdsp_pkg::H_CNT_W-1:0] h_cnt,
    input  logic [gdsp_pkg::V_CNT_W-1:0] v_cnt,
    input  logic                         video_active,
    input  logic                         pixel_hit,
    input  logic [1:0]                   hit_quadrant,
    output logic [23:0]                  rgb_pixel
);

    logic [23:0] dot_color;
    logic        on_axis;
    logic        on_border;

    // Quadrant to colour, upper bit is the top half
    always_comb begin
        case (hit_quadrant)
            2'b11:   dot_color = gdsp_pkg::COLOR_Q1;
            2'b10:   dot_color = gdsp_pkg::COLOR_Q2;
            2'b00:   dot_color = gdsp_pkg::COLOR_Q3;
            default: dot_color = gdsp_pkg::COLOR_Q4;
        endcase
    end

    // Centre cross, one pixel wide
    assign on_axis = (h_cnt == gdsp_pkg::H_CNT_W'(gdsp_pkg::CENTER_X)) ||
                     (v_cnt == gdsp_pkg::V_CNT_W'(gdsp_pkg::CENTER_Y));

    // Outermost ring of the active area
    assign on_border = (h_cnt == '0) ||
                       (h_cnt == gdsp_pkg::H_CNT_W'(gdsp_pkg::H_ACTIVE - 1)) ||
                       (v_cnt == '0) ||
                       (v_cnt == gdsp_pkg::V_CNT_W'(gdsp_pkg::V_ACTIVE - 1));

    // Registered like de, so colour and enable line up
    always_ff @(posedge clk_pixel or negedge rst_n) begin
        if (!rst_n) begin
            rgb_pixel <= gdsp_pkg::COLOR_BLACK;
        end else if (!video_active) begin
            rgb_pixel <= gdsp_pkg::COLOR_BLACK;
        end else if (pixel_hit) begin
            // Dots are drawn over the axes and border
            rgb_pixel <= dot_color;
        end else if (on_axis) begin
            rgb_pixel <= gdsp_pkg::COLOR_AXIS;
        end else if (on_border) begin
            rgb_pixel <= gdsp_pkg::COLOR_BORDER;
        end else begin
            rgb_pixel <= gdsp_pkg::COLOR_BLACK;
        end
    end

endmodule : pixel_colorizer

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the constellation renderer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 -Wno-fatal --top-module tb_constellation_renderer -f sim.f

output=$(./obj_dir/Vtb_constellation_renderer 2>&1 || true)
echo "$output"

if echo "$output" | grep -q "All checks passed"; then
    exit 0
fi
exit 1

// ==== sim.f ====
gdsp_pkg.sv
video_timing_gen.sv
symbol_mapper.sv
dot_store.sv
pixel_colorizer.sv
constellation_renderer.sv
tb_constellation_renderer.sv

// ==== symbol_mapper.sv ====
// Symbol mapper
// Synchronises the symbol strobe into the pixel domain and turns the I/Q
// samples into a clipped screen position with a one-cycle write pulse
`timescale 1ns/1ns

module symbol_mapper (
    input  logic                                clk_pixel,
    input  logic                                rst_n,
    input  logic signed [gdsp_pkg::SAMPLE_W-1:0] sym_i,
    input  logic signed [gdsp_pkg::SAMPLE_W-1:0] sym_q,
    input  logic                                sym_valid,
    output logic        [gdsp_pkg::H_CNT_W-1:0]  dot_x,
    output logic        [gdsp_pkg::V_CNT_W-1:0]  dot_y,
    output logic                                dot_write
);

    // Three synchroniser flops, oldest in bit 2
    logic [2:0] sync_ff;

    // I path, divided, then compressed by 3/4 with rounding
    logic signed [gdsp_pkg::SAMPLE_W-1:0] i_div;
    logic signed [gdsp_pkg::SAMPLE_W+1:0] i_tri;
    logic signed [gdsp_pkg::SAMPLE_W+1:0] i_comp;
    logic signed [gdsp_pkg::SAMPLE_W+1:0] x_sum;

    // Q path, divided only
    logic signed [gdsp_pkg::SAMPLE_W-1:0] q_div;
    logic signed [gdsp_pkg::SAMPLE_W+1:0] y_sum;

    // ====================
    // Strobe synchroniser
    // ====================
    // Edge sampled into bit 0, write pulse follows three cycles later
    always_ff @(posedge clk_pixel or negedge rst_n) begin
        if (!rst_n) begin
            sync_ff   <= '0;
            dot_write <= 1'b0;
        end else begin
            sync_ff   <= {sync_ff[1:0], sym_valid};
            // Single pulse per rising edge, a long level gives one write
            dot_write <= sync_ff[1] && !sync_ff[2];
        end
    end

    // ====================
    // Coordinate mapping
    // ====================
    // Anamorphic X, (I/8 * 3 + 2) / 4
    assign i_div  = sym_i >>> gdsp_pkg::SAMPLE_SHIFT;
    assign i_tri  = i_div * 14'sd3 + 14'sd2;
    assign i_comp = i_tri >>> 2;
    assign x_sum  = $signed(14'(gdsp_pkg::CENTER_X)) + i_comp;

    // Screen Y grows downward, so positive Q goes up
    assign q_div = sym_q >>> gdsp_pkg::SAMPLE_SHIFT;
    assign y_sum = $signed(14'(gdsp_pkg::CENTER_Y)) - q_div;

    // Clip into the active area
    always_comb begin
        if (x_sum < 0) begin
            dot_x = '0;
        end else if (x_sum > $signed(14'(gdsp_pkg::H_ACTIVE - 1))) begin
            dot_x = gdsp_pkg::H_CNT_W'(gdsp_pkg::H_ACTIVE - 1);
        end else begin
            dot_x = x_sum[gdsp_pkg::H_CNT_W-1:0];
        end

        if (y_sum < 0) begin
            dot_y = '0;
        end else if (y_sum > $signed(14'(gdsp_pkg::V_ACTIVE - 1))) begin
            // Q of -2048 lands here, on the bottom row
            dot_y = gdsp_pkg::V_CNT_W'(gdsp_pkg::V_ACTIVE - 1);
        end else begin
            dot_y = y_sum[gdsp_pkg::V_CNT_W-1:0];
        end
    end

endmodule : symbol_mapper

// ==== tb_constellation_renderer.sv ====
// Testbench for the constellation renderer
// Checks raster timing, background, dot placement, clipping and per-frame decay
`timescale 1ns/1ns

module tb_constellation_renderer;

    localparam int FRAME_TIMEOUT = 2 * gdsp_pkg::H_TOTAL * gdsp_pkg::V_TOTAL;

    logic                                 clk_pixel = 1'b0;
    logic                                 rst_n;
    logic signed [gdsp_pkg::SAMPLE_W-1:0] sym_i;
    logic signed [gdsp_pkg::SAMPLE_W-1:0] sym_q;
    logic                                 sym_valid;
    logic [23:0]                          rgb_pixel;
    logic                                 hsync;
    logic                                 vsync;
    logic                                 de;

    // Dots expected in the coming active frame
    int          exp_col [16];
    int          exp_row [16];
    logic [23:0] exp_color [16];
    int          dot_count = 0;
    int          seed = 51112;

    // Monitor state with cycle stamps in negedge counts
    int cyc = 0;
    int col = 0;
    int row = -1;
    int de_cnt = 0;
    int active_lines = 0;
    int frame_lines = 0;
    int hs_rise_cyc = 0;
    int de_fall_cyc = 0;
    int vs_rise_cyc = 0;
    int frames_checked = 0;
    bit framed = 0;
    bit seen_hs = 0;
    bit seen_de_fall = 0;
    bit prev_de = 0;
    bit prev_hs = 0;
    bit prev_vs = 0;

    constellation_renderer i_dut (
        .clk_pixel (clk_pixel),
        .rst_n     (rst_n),
        .sym_i     (sym_i),
        .sym_q     (sym_q),
        .sym_valid (sym_valid),
        .rgb_pixel (rgb_pixel),
        .hsync     (hsync),
        .vsync     (vsync),
        .de        (de)
    );

    always #2 clk_pixel = ~clk_pixel;

    task automatic fail_check(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic fail_timeout(input string what);
        $display("Timed out while waiting for %s", what);
        $display("Checks failed");
        $fatal(1);
    endtask

    // ====================
    // Reference model
    // ====================
    // Column is (I/8 * 3 + 2) / 4 floored and row is centre minus Q/8
    function automatic void ref_map(input int i, input int q, output int c, output int r,
                                    output logic [23:0] color);
        c = (((i >>> gdsp_pkg::SAMPLE_SHIFT) * 3 + 2) >>> 2) + gdsp_pkg::CENTER_X;
        r = gdsp_pkg::CENTER_Y - (q >>> gdsp_pkg::SAMPLE_SHIFT);
        c = (c < 0) ? 0 : (c > gdsp_pkg::H_ACTIVE - 1) ? gdsp_pkg::H_ACTIVE - 1 : c;
        r = (r < 0) ? 0 : (r > gdsp_pkg::V_ACTIVE - 1) ? gdsp_pkg::V_ACTIVE - 1 : r;
        // Quadrants counted anticlockwise from upper right
        if (r < gdsp_pkg::CENTER_Y) begin
            color = (c >= gdsp_pkg::CENTER_X) ? gdsp_pkg::COLOR_Q1 : gdsp_pkg::COLOR_Q2;
        end else begin
            color = (c >= gdsp_pkg::CENTER_X) ? gdsp_pkg::COLOR_Q4 : gdsp_pkg::COLOR_Q3;
        end
    endfunction

    function automatic logic [23:0] expected_pixel(input int x, input int y);
        logic [23:0] color;
        if (x == gdsp_pkg::CENTER_X || y == gdsp_pkg::CENTER_Y) begin
            color = gdsp_pkg::COLOR_AXIS;
        end else if (x == 0 || x == gdsp_pkg::H_ACTIVE - 1 ||
                     y == 0 || y == gdsp_pkg::V_ACTIVE - 1) begin
            color = gdsp_pkg::COLOR_BORDER;
        end else begin
            color = gdsp_pkg::COLOR_BLACK;
        end
        // Later dots paint over earlier ones
        for (int k = 0; k < dot_count; k++) begin
            if (x >= exp_col[k] && x < exp_col[k] + gdsp_pkg::DOT_SIZE &&
                y >= exp_row[k] && y < exp_row[k] + gdsp_pkg::DOT_SIZE) begin
                color = exp_color[k];
            end
        end
        return color;
    endfunction

    function automatic void add_expected(input int i, input int q);
        ref_map(i, q, exp_col[dot_count], exp_row[dot_count], exp_color[dot_count]);
        dot_count++;
    endfunction

    // Keeps at least 64 away from zero so dots sit clear of the axes
    function automatic int random_sample();
        int v;
        v = $random(seed) % 1984;
        return (v < 0) ? v - 64 : v + 64;
    endfunction

    // ====================
    // Stimulus helpers
    // ====================
    task automatic wait_vsync_rise();
        int  n;
        logic seen_low;
        n = 0;
        seen_low = 1'b0;
        while (!(seen_low && vsync)) begin
            @(negedge clk_pixel);
            if (!vsync) begin
                seen_low = 1'b1;
            end
            n++;
            if (n > FRAME_TIMEOUT) begin
                fail_timeout("a rising edge of vsync");
            end
        end
        // Store clears one cycle after the new frame starts
        dot_count = 0;
        repeat (4) @(negedge clk_pixel);
    endtask

    // Strobe high for 4 cycles then low for 4
    task automatic send_symbol(input int i, input int q);
        sym_i     = gdsp_pkg::SAMPLE_W'(i);
        sym_q     = gdsp_pkg::SAMPLE_W'(q);
        sym_valid = 1'b1;
        add_expected(i, q);
        repeat (4) @(negedge clk_pixel);
        sym_valid = 1'b0;
        repeat (4) @(negedge clk_pixel);
    endtask

    initial begin
        rst_n     = 1'b0;
        sym_i     = '0;
        sym_q     = '0;
        sym_valid = 1'b0;
        repeat (3) @(posedge clk_pixel);
        @(negedge clk_pixel);
        rst_n = 1'b1;

        // Background frame with no symbols
        wait_vsync_rise();
        // Random constellation points
        wait_vsync_rise();
        for (int s = 0; s < 12; s++) begin
            send_symbol(random_sample(), random_sample());
        end
        // Extremes and clipping with Q of -2048 on the last row
        wait_vsync_rise();
        send_symbol(-2048, -2048);
        send_symbol(2047, 2047);
        send_symbol(-2048, 2047);
        send_symbol(2047, -2048);
        send_symbol(0, -2048);
        // Long strobe whose samples move after the first write
        wait_vsync_rise();
        sym_i     = 12'sd1024;
        sym_q     = 12'sd1024;
        sym_valid = 1'b1;
        add_expected(1024, 1024);
        repeat (8) @(negedge clk_pixel);
        sym_i = -12'sd1024;
        sym_q = -12'sd1024;
        repeat (200) @(negedge clk_pixel);
        sym_valid = 1'b0;
        // Empty frame without the previous dots
        wait_vsync_rise();
        wait_vsync_rise();
        repeat (4) @(negedge clk_pixel);
        if (frames_checked == 5) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Only %0d of 5 frames were fully checked", frames_checked);
            $display("Checks failed");
            $fatal(1);
        end
    end

    // ====================
    // Output monitor
    // ====================
    always @(negedge clk_pixel) begin
        if (rst_n) begin
            cyc++;
            if (de && !prev_de) begin
                row++;
                col = 0;
                de_cnt = 0;
                active_lines++;
            end
            if (de) begin
                de_cnt++;
                if (framed) begin
                    assert (rgb_pixel == expected_pixel(col, row)) else
                        fail_check($sformatf("pixel (%0d,%0d) is %h, expected %h", col, row,
                                             rgb_pixel, expected_pixel(col, row)));
                end
                col++;
            end else begin
                assert (rgb_pixel == gdsp_pkg::COLOR_BLACK) else
                    fail_check($sformatf("rgb_pixel is %h while de is low", rgb_pixel));
            end
            if (!de && prev_de) begin
                assert (de_cnt == gdsp_pkg::H_ACTIVE) else
                    fail_check($sformatf("line has %0d de cycles", de_cnt));
                de_fall_cyc  = cyc;
                seen_de_fall = 1;
            end
            if (hsync && !prev_hs) begin
                if (seen_hs) begin
                    assert (cyc - hs_rise_cyc == gdsp_pkg::H_TOTAL) else
                        fail_check($sformatf("line period is %0d", cyc - hs_rise_cyc));
                end
                // Front porch only on lines that carried video
                if (seen_de_fall && cyc - de_fall_cyc < gdsp_pkg::H_TOTAL) begin
                    assert (cyc - de_fall_cyc == gdsp_pkg::H_FP) else
                        fail_check($sformatf("hsync starts %0d after de", cyc - de_fall_cyc));
                end
                hs_rise_cyc = cyc;
                seen_hs     = 1;
                frame_lines++;
            end
            if (!hsync && prev_hs) begin
                assert (cyc - hs_rise_cyc == gdsp_pkg::H_SYNC) else
                    fail_check($sformatf("hsync width is %0d", cyc - hs_rise_cyc));
            end
            if (vsync && !prev_vs) begin
                if (framed) begin
                    assert (active_lines == gdsp_pkg::V_ACTIVE) else
                        fail_check($sformatf("frame has %0d active lines", active_lines));
                    assert (frame_lines == gdsp_pkg::V_TOTAL) else
                        fail_check($sformatf("frame has %0d lines", frame_lines));
                    frames_checked++;
                end
                framed       = 1;
                row          = -1;
                active_lines = 0;
                frame_lines  = 0;
                vs_rise_cyc  = cyc;
            end
            if (!vsync && prev_vs) begin
                assert (cyc - vs_rise_cyc == gdsp_pkg::V_SYNC * gdsp_pkg::H_TOTAL) else
                    fail_check($sformatf("vsync width is %0d cycles", cyc - vs_rise_cyc));
            end
            prev_de = de;
            prev_hs = hsync;
            prev_vs = vsync;
        end
    end

endmodule : tb_constellation_renderer

// ==== video_timing_gen.sv ====
// Video timing generator for 640x480 at 60 Hz
// Free-running pixel and line counters, registered sync and data enable,
// and a one-cycle clear pulse at the start of each vertical sync
`timescale 1ns/1ns

module video_timing_gen (
    input  logic                         clk_pixel,
    input  logic                         rst_n,
    output logic [gdsp_pkg::H_CNT_W-1:0] h_cnt,
    output logic [gdsp_pkg::V_CNT_W-1:0] v_cnt,
    output logic                         video_active,
    output logic                         hsync,
    output logic                         vsync,
    output logic                         de,
    output logic                         frame_clear
);

    logic h_sync_region;
    logic v_sync_region;
    logic vsync_d;

    // ====================
    // Counters
    // ====================
    // Pixel counter wraps at 800, line counter steps once per line
    always_ff @(posedge clk_pixel or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == gdsp_pkg::H_CNT_W'(gdsp_pkg::H_TOTAL - 1)) begin
            h_cnt <= '0;
            if (v_cnt == gdsp_pkg::V_CNT_W'(gdsp_pkg::V_TOTAL - 1)) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // Inside the 640x480 window, same cycle as the counters
    assign video_active = (h_cnt < gdsp_pkg::H_ACTIVE) && (v_cnt < gdsp_pkg::V_ACTIVE);

    // Sync windows, columns 656..751 and rows 490..491
    assign h_sync_region = (h_cnt >= gdsp_pkg::H_ACTIVE + gdsp_pkg::H_FP) &&
                           (h_cnt <  gdsp_pkg::H_ACTIVE + gdsp_pkg::H_FP + gdsp_pkg::H_SYNC);
    assign v_sync_region = (v_cnt >= gdsp_pkg::V_ACTIVE + gdsp_pkg::V_FP) &&
                           (v_cnt <  gdsp_pkg::V_ACTIVE + gdsp_pkg::V_FP + gdsp_pkg::V_SYNC);

    // ====================
    // Registered outputs
    // ====================
    // One cycle behind the counters, sync active high
    always_ff @(posedge clk_pixel or negedge rst_n) begin
        if (!rst_n) begin
            hsync       <= 1'b0;
            vsync       <= 1'b0;
            de          <= 1'b0;
            vsync_d     <= 1'b0;
            frame_clear <= 1'b0;
        end else begin
            hsync       <= h_sync_region;
            vsync       <= v_sync_region;
            de          <= video_active;
            vsync_d     <= vsync;
            // Rising edge of the registered vsync, seen one cycle later
            frame_clear <= vsync && !vsync_d;
        end
    end

endmodule : video_timing_gen
